//--- fpu_issue.sv
// FPU issue selector
// picks one ready slot for FPU 0 and a different one for FPU 1 and
// registers both one-hot masks under the clock enable
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module fpu_issue import iq_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ce,
	input  logic [1:0] allow_issue,
	input  iq_mask_t   could_issue,
	input  iq_mask_t   iq_fpu,
	input  iq_mask_t   iq_fpu0,
	input  iq_mask_t   iq_prior_sync,
	input  iq_mask_t   iq_prior_fsync,
	input  logic       fpu0_idle,
	input  logic       fpu1_idle,
	output iq_mask_t   issue0,
	output iq_mask_t   issue1
);

	iq_mask_t ready;
	iq_mask_t issue0_next;
	iq_mask_t issue1_next;

	// an entry behind any older barrier waits, whatever its kind
	assign ready = could_issue & iq_fpu & ~(iq_prior_sync | iq_prior_fsync);

	// lowest slot index wins, age does not matter here
	always_comb begin
		issue0_next = '0;
		issue1_next = '0;
		if (fpu0_idle && allow_issue[0]) begin
			for (int n = 0; n < `IQ_ENTRIES; n++) begin
				if (ready[n] && issue0_next == '0)
					issue0_next[n] = 1'b1;
			end
		end
		// FPU 1 skips fpu0_only entries and the slot FPU 0 just took
		if (fpu1_idle && allow_issue[1] && `NUM_FPU > 1) begin
			for (int n = 0; n < `IQ_ENTRIES; n++) begin
				if (ready[n] && !iq_fpu0[n] && !issue0_next[n] && issue1_next == '0)
					issue1_next[n] = 1'b1;
			end
		end
	end

	// with ce low both masks hold, the queue and FPUs ignore the repeat
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue0 <= '0;
			issue1 <= '0;
		end else if (ce) begin
			issue0 <= issue0_next;
			issue1 <= issue1_next;
		end
	end

endmodule

//--- fpu_issue_defines.svh
// sizing macros for the floating-point issue stage
// queue depth, number of FPUs in use and the fixed FPU latency
`ifndef FPU_ISSUE_DEFINES_SVH
`define FPU_ISSUE_DEFINES_SVH

// number of issue queue slots, a power of two so slot indices wrap
`define IQ_ENTRIES 8

// number of FPUs that take work
// with 1 the selector never fills the FPU 1 issue mask
`define NUM_FPU 2

// cycles from the issue mask cycle to the result valid cycle
// the FPU also stays busy for this many cycles after it starts
`define FPU_LATENCY 2

`endif

//--- fpu_issue_top.f
+incdir+.
fpu_pkg.sv
iq_pkg.sv
issue_queue.sv
iq_sync_scan.sv
fpu_issue.sv
fpu_unit.sv
fpu_issue_top.sv
tb_fpu_issue_top.sv

//--- fpu_issue_top.sv
// top of the floating-point issue stage
// issue queue, barrier scan, selector and two FPUs, plus the one-hot
// operand select from the queue slots into each FPU
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module fpu_issue_top import fpu_pkg::*, iq_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         dispatch_valid,
	input  iq_dispatch_t dispatch,
	input  logic         issue_ce,
	input  logic [1:0]   fpu_enable,
	output logic         queue_full,
	output fpu_result_t  result0,
	output fpu_result_t  result1
);

	iq_mask_t could_issue;
	iq_mask_t iq_fpu;
	iq_mask_t iq_fpu0;
	iq_mask_t iq_valid;
	iq_mask_t iq_sync;
	iq_mask_t iq_fsync;
	iq_mask_t iq_prior_sync;
	iq_mask_t iq_prior_fsync;
	iq_mask_t issue0;
	iq_mask_t issue1;
	iq_idx_t  head;
	fpu_op_t  slot_op [`IQ_ENTRIES];
	iq_tag_t  slot_tag [`IQ_ENTRIES];
	fpu_op_t  op0;
	fpu_op_t  op1;
	iq_tag_t  tag0;
	iq_tag_t  tag1;
	logic     start0;
	logic     start1;
	logic     fpu0_idle;
	logic     fpu1_idle;

	// a held mask points at a slot already freed, so it starts nothing
	assign start0 = |(issue0 & iq_valid);
	assign start1 = |(issue1 & iq_valid);

	// the masks are one-hot, so the last match is the only match
	always_comb begin
		op0 = '0;
		op1 = '0;
		tag0 = '0;
		tag1 = '0;
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			if (issue0[i]) begin
				op0 = slot_op[i];
				tag0 = slot_tag[i];
			end
			if (issue1[i]) begin
				op1 = slot_op[i];
				tag1 = slot_tag[i];
			end
		end
	end

	issue_queue u_queue (
		.clk            (clk),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.issue0         (issue0),
		.issue1         (issue1),
		.fpu_all_idle   (fpu0_idle && fpu1_idle),
		.could_issue    (could_issue),
		.iq_fpu         (iq_fpu),
		.iq_fpu0        (iq_fpu0),
		.iq_valid       (iq_valid),
		.iq_sync        (iq_sync),
		.iq_fsync       (iq_fsync),
		.head           (head),
		.slot_op        (slot_op),
		.slot_tag       (slot_tag),
		.queue_full     (queue_full)
	);

	iq_sync_scan u_scan (
		.iq_valid       (iq_valid),
		.iq_sync        (iq_sync),
		.iq_fsync       (iq_fsync),
		.head           (head),
		.iq_prior_sync  (iq_prior_sync),
		.iq_prior_fsync (iq_prior_fsync)
	);

	fpu_issue u_issue (
		.clk            (clk),
		.arst_n         (arst_n),
		.ce             (issue_ce),
		.allow_issue    (fpu_enable),
		.could_issue    (could_issue),
		.iq_fpu         (iq_fpu),
		.iq_fpu0        (iq_fpu0),
		.iq_prior_sync  (iq_prior_sync),
		.iq_prior_fsync (iq_prior_fsync),
		.fpu0_idle      (fpu0_idle),
		.fpu1_idle      (fpu1_idle),
		.issue0         (issue0),
		.issue1         (issue1)
	);

	fpu_unit u_fpu0 (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start0),
		.op     (op0),
		.tag    (tag0),
		.idle   (fpu0_idle),
		.result (result0)
	);

	fpu_unit u_fpu1 (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start1),
		.op     (op1),
		.tag    (tag1),
		.idle   (fpu1_idle),
		.result (result1)
	);

endmodule

//--- fpu_pkg.sv
// types that describe FPU work
// the data word, the tag vector, the opcode enum and the operation and
// result structs that pass between the queue and the FPUs
package fpu_pkg;

	// one IEEE single-precision word
	typedef logic [31:0] fpu_word_t;

	// tag width as the dispatcher assigns it
	// the queue reuses this vector as its own tag type
	typedef logic [5:0] fpu_tag_t;

	// the sign and compare class of operations
	typedef enum logic [2:0] {
		op_fneg  = 3'd0,
		op_fabs  = 3'd1,
		op_fsgnj = 3'd2,
		op_fmin  = 3'd3,
		op_fmax  = 3'd4
	} fpu_opcode_e;

	// one operation with both source operands, 67 bits
	typedef struct packed {
		fpu_opcode_e opcode;
		fpu_word_t   a;
		fpu_word_t   b;
	} fpu_op_t;

	// what an FPU hands back, 39 bits
	typedef struct packed {
		logic      valid;
		fpu_tag_t  tag;
		fpu_word_t value;
	} fpu_result_t;

endpackage

//--- fpu_unit.sv
// one fixed-latency FPU
// sign and compare datapath, a shift pipeline for valid, tag and value,
// and the idle flag used by the selector and the fsync barrier
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module fpu_unit import fpu_pkg::*, iq_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        start,
	input  fpu_op_t     op,
	input  iq_tag_t     tag,
	output logic        idle,
	output fpu_result_t result
);

	localparam fpu_word_t canonical_nan = 32'h7fc0_0000;

	logic [`FPU_LATENCY-1:0] vld_pipe;
	iq_tag_t                 tag_pipe [`FPU_LATENCY];
	fpu_word_t               val_pipe [`FPU_LATENCY];
	fpu_word_t               value;

	// all-ones exponent with a nonzero fraction
	function automatic logic is_nan(input fpu_word_t w);
		return (w[30:23] == 8'hff) && (w[22:0] != '0);
	endfunction

	// sign-magnitude order, so -0 sorts below +0
	function automatic logic less_than(input fpu_word_t a, input fpu_word_t b);
		if (a[31] != b[31])
			return a[31];
		if (a[31])
			return a[30:0] > b[30:0];
		return a[30:0] < b[30:0];
	endfunction

	always_comb begin
		logic a_lt_b;
		a_lt_b = less_than(op.a, op.b);
		case (op.opcode)
			op_fneg:  value = {~op.a[31], op.a[30:0]};
			op_fabs:  value = {1'b0, op.a[30:0]};
			op_fsgnj: value = {op.b[31], op.a[30:0]};
			op_fmin, op_fmax: begin
				// a single NaN input loses to the number
				if (is_nan(op.a) && is_nan(op.b))
					value = canonical_nan;
				else if (is_nan(op.a))
					value = op.b;
				else if (is_nan(op.b))
					value = op.a;
				else if ((op.opcode == op_fmin) == a_lt_b)
					value = op.a;
				else
					value = op.b;
			end
			default:  value = canonical_nan;
		endcase
	end

	// =========================================================================
	// latency pipeline
	// =========================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= start;
			for (int i = 1; i < `FPU_LATENCY; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		tag_pipe[0] <= tag;
		val_pipe[0] <= value;
		for (int i = 1; i < `FPU_LATENCY; i++) begin
			tag_pipe[i] <= tag_pipe[i-1];
			val_pipe[i] <= val_pipe[i-1];
		end
	end

	// busy while any stage holds work, start counts too so one pick per op
	assign idle = !(|vld_pipe) && !start;

	assign result.valid = vld_pipe[`FPU_LATENCY-1];
	assign result.tag = tag_pipe[`FPU_LATENCY-1];
	assign result.value = val_pipe[`FPU_LATENCY-1];

endmodule

//--- iq_pkg.sv
// types that describe the issue queue
// slot mask, slot index, tag, entry kind and the dispatch struct
`include "fpu_issue_defines.svh"

package iq_pkg;

	import fpu_pkg::*;

	// one bit per queue slot
	typedef logic [`IQ_ENTRIES-1:0] iq_mask_t;

	// index of one queue slot
	typedef logic [$clog2(`IQ_ENTRIES)-1:0] iq_idx_t;

	// instruction tag from the dispatcher
	typedef fpu_tag_t iq_tag_t;

	// an entry is either real FPU work or one of the two barriers
	typedef enum logic [1:0] {
		kind_fp_op = 2'd0,
		kind_sync  = 2'd1,
		kind_fsync = 2'd2
	} iq_kind_e;

	// everything the dispatcher writes into a slot
	typedef struct packed {
		iq_kind_e kind;
		iq_tag_t  tag;
		logic     fpu0_only;
		fpu_op_t  op;
	} iq_dispatch_t;

endpackage

//--- iq_sync_scan.sv
// barrier scan for the issue queue
// walks the slots in age order from the head and flags every slot that
// has an older valid sync or fsync in front of it
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module iq_sync_scan import iq_pkg::*; (
	input  iq_mask_t iq_valid,
	input  iq_mask_t iq_sync,
	input  iq_mask_t iq_fsync,
	input  iq_idx_t  head,
	output iq_mask_t iq_prior_sync,
	output iq_mask_t iq_prior_fsync
);

	// prefix OR in ring order, the head itself never sees a prior barrier
	always_comb begin
		iq_idx_t idx;
		logic    seen_sync;
		logic    seen_fsync;
		iq_prior_sync = '0;
		iq_prior_fsync = '0;
		seen_sync = 1'b0;
		seen_fsync = 1'b0;
		for (int k = 0; k < `IQ_ENTRIES; k++) begin
			idx = head + iq_idx_t'(k);
			// a slot's flag only covers entries strictly older than it
			iq_prior_sync[idx] = seen_sync;
			iq_prior_fsync[idx] = seen_fsync;
			// holes left by issued entries do not block anything
			if (iq_valid[idx]) begin
				seen_sync = seen_sync | iq_sync[idx];
				seen_fsync = seen_fsync | iq_fsync[idx];
			end
		end
	end

endmodule

//--- issue_queue.sv
// floating-point issue queue
// slot storage, allocation at the tail, freeing of issued slots,
// retirement of barriers at the head and the per-slot status masks
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module issue_queue import fpu_pkg::*, iq_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         dispatch_valid,
	input  iq_dispatch_t dispatch,
	input  iq_mask_t     issue0,
	input  iq_mask_t     issue1,
	input  logic         fpu_all_idle,
	output iq_mask_t     could_issue,
	output iq_mask_t     iq_fpu,
	output iq_mask_t     iq_fpu0,
	output iq_mask_t     iq_valid,
	output iq_mask_t     iq_sync,
	output iq_mask_t     iq_fsync,
	output iq_idx_t      head,
	output fpu_op_t      slot_op [`IQ_ENTRIES],
	output iq_tag_t      slot_tag [`IQ_ENTRIES],
	output logic         queue_full
);

	// one extra bit over the index, since at most IQ_ENTRIES dispatches
	// separate the oldest live entry from the sequence counter
	localparam int seq_w = $clog2(`IQ_ENTRIES) + 1;

	iq_mask_t         slot_valid;
	iq_mask_t         slot_issued;
	iq_mask_t         slot_fpu0;
	iq_kind_e         slot_kind [`IQ_ENTRIES];
	logic [seq_w-1:0] slot_seq [`IQ_ENTRIES];
	logic [seq_w-1:0] seq_ctr;
	iq_idx_t          tail;
	iq_idx_t          alloc_idx;
	logic             alloc_ok;
	logic             do_alloc;
	iq_mask_t         retire;
	iq_mask_t         in_issue;

	// =========================================================================
	// head and allocation
	// =========================================================================

	// the head is the valid slot with the largest age, counted as the
	// distance from its sequence number to the next one to hand out
	always_comb begin
		logic [seq_w-1:0] age;
		logic [seq_w-1:0] best_age;
		logic             found;
		head = tail;
		best_age = '0;
		found = 1'b0;
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			age = seq_ctr - slot_seq[i];
			if (slot_valid[i] && (!found || age > best_age)) begin
				head = iq_idx_t'(i);
				best_age = age;
				found = 1'b1;
			end
		end
	end

	// search forward from the tail for a slot that is empty and not still
	// named by a held issue mask
	// the search stops at the head so ring order from the head stays age order
	always_comb begin
		iq_idx_t idx;
		logic    stop;
		alloc_ok = 1'b0;
		alloc_idx = tail;
		stop = 1'b0;
		for (int k = 0; k < `IQ_ENTRIES; k++) begin
			idx = tail + iq_idx_t'(k);
			if (|slot_valid && idx == head)
				stop = 1'b1;
			if (!stop && !alloc_ok && !slot_valid[idx] && !slot_issued[idx]) begin
				alloc_ok = 1'b1;
				alloc_idx = idx;
			end
		end
	end

	assign queue_full = !alloc_ok;
	assign do_alloc = dispatch_valid && alloc_ok;

	// a sync leaves as soon as it is the oldest entry
	// an fsync also waits for both FPUs to drain
	always_comb begin
		retire = '0;
		if (slot_valid[head]) begin
			if (slot_kind[head] == kind_sync)
				retire[head] = 1'b1;
			if (slot_kind[head] == kind_fsync && fpu_all_idle)
				retire[head] = 1'b1;
		end
	end

	// =========================================================================
	// status masks
	// =========================================================================

	assign in_issue = issue0 | issue1;
	assign iq_valid = slot_valid;
	assign iq_fpu0 = slot_valid & slot_fpu0;

	always_comb begin
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			iq_fpu[i] = slot_valid[i] && slot_kind[i] == kind_fp_op;
			iq_sync[i] = slot_valid[i] && slot_kind[i] == kind_sync;
			iq_fsync[i] = slot_valid[i] && slot_kind[i] == kind_fsync;
		end
	end

	// a slot named by this cycle's masks is already on its way to an FPU
	assign could_issue = iq_fpu & ~in_issue;

	// =========================================================================
	// state update
	// =========================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_valid <= '0;
			slot_issued <= '0;
			tail <= '0;
			seq_ctr <= '0;
		end else begin
			// the issued flag is set on the first mask cycle and kept until
			// the mask lets go, so a held mask never frees a later entry
			slot_issued <= in_issue & (slot_issued | slot_valid);
			slot_valid <= slot_valid & ~in_issue & ~retire;
			if (do_alloc) begin
				slot_valid[alloc_idx] <= 1'b1;
				tail <= alloc_idx + iq_idx_t'(1);
				seq_ctr <= seq_ctr + 1'b1;
			end
		end
	end

	// slot payload is only read while the slot is valid
	always_ff @(posedge clk) begin
		if (do_alloc) begin
			slot_kind[alloc_idx] <= dispatch.kind;
			slot_tag[alloc_idx] <= dispatch.tag;
			slot_fpu0[alloc_idx] <= dispatch.fpu0_only;
			slot_op[alloc_idx] <= dispatch.op;
			slot_seq[alloc_idx] <= seq_ctr;
		end
	end

endmodule

//--- tb_fpu_issue_top.sv
// testbench for the floating-point issue stage
// stimulus table of dispatch and pause rows applied in a loop, a Galois LFSR
// for extra FMIN and FMAX operands, a scoreboard indexed by tag, typed
// compare tasks, barrier ordering and pause checks, and a cycle limit
`timescale 1ns/1ps
`include "fpu_issue_defines.svh"

module tb_fpu_issue_top import fpu_pkg::*, iq_pkg::*; ();

	localparam int max_rows = 96;
	localparam int reset_cycles = 16;
	// cycles after a pause starts before nothing may still be in flight
	localparam int drain_cycles = `FPU_LATENCY + 2;

	// one table row, either a dispatch or a pause of issue
	typedef struct packed {
		logic        is_pause;
		iq_kind_e    kind;
		fpu_opcode_e opcode;
		fpu_word_t   a;
		fpu_word_t   b;
		logic        fpu0_only;
		fpu_word_t   expected;
		logic [7:0]  pause_len;
		logic        pause_ce;
		logic [1:0]  pause_en;
	} row_t;

	logic         clk;
	logic         arst_n;
	logic         dispatch_valid;
	iq_dispatch_t dispatch;
	logic         issue_ce;
	logic [1:0]   fpu_enable;
	logic         queue_full;
	fpu_result_t  result0;
	fpu_result_t  result1;

	row_t        rows [max_rows];
	int          n_rows;
	logic [31:0] lfsr_state;

	// scoreboard, one entry per tag
	logic      pending [64];
	fpu_word_t exp_val [64];
	logic      exp_fpu0 [64];
	int        exp_epoch [64];
	int        disp_cyc [64];
	// the epoch counts the barriers dispatched before an fp_op
	int        outstanding [64];
	int        open_count;
	int        epoch;
	iq_tag_t   tag_ctr;

	int         cyc;
	int         cycle_limit;
	int         pause_left;
	logic       pause_active;
	logic       pause_ce_r;
	logic [1:0] pause_en_r;
	int         pause_age;
	// set once the queue has reported itself full
	logic       saw_full;

	fpu_issue_top u_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.issue_ce       (issue_ce),
		.fpu_enable     (fpu_enable),
		.queue_full     (queue_full),
		.result0        (result0),
		.result1        (result1)
	);

	always #10 clk = ~clk;

	// =========================================================================
	// reference model and random source
	// =========================================================================

	// one Galois step, the bit that falls out is the random bit
	function logic lfsr_step();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	function logic [31:0] random_word(input int nbits);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < nbits; i++)
			w = {w[30:0], lfsr_step()};
		return w;
	endfunction

	// maps a word onto an unsigned key that sorts like the number
	// negative words invert so larger magnitudes land lower, -0 sits below +0
	function automatic fpu_word_t minmax_model(input logic want_max, input fpu_word_t a,
			input fpu_word_t b);
		logic        a_nan;
		logic        b_nan;
		logic [31:0] ka;
		logic [31:0] kb;
		a_nan = (&a[30:23]) && (|a[22:0]);
		b_nan = (&b[30:23]) && (|b[22:0]);
		if (a_nan && b_nan)
			return 32'h7fc0_0000;
		if (a_nan)
			return b;
		if (b_nan)
			return a;
		ka = a[31] ? ~a : {1'b1, a[30:0]};
		kb = b[31] ? ~b : {1'b1, b[30:0]};
		if (want_max)
			return (ka > kb) ? a : b;
		return (ka < kb) ? a : b;
	endfunction

	// =========================================================================
	// table
	// =========================================================================

	task automatic add_op(input iq_kind_e kind, input fpu_opcode_e opc, input fpu_word_t a,
			input fpu_word_t b, input logic fpu0, input fpu_word_t expected);
		rows[n_rows] = '{1'b0, kind, opc, a, b, fpu0, expected, 8'd0, 1'b1, 2'b11};
		n_rows++;
	endtask

	task automatic add_pause(input int len, input logic ce, input logic [1:0] en);
		rows[n_rows] = '{1'b1, kind_fp_op, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0, 8'(len), ce, en};
		n_rows++;
	endtask

	task automatic build_table();
		fpu_word_t a;
		fpu_word_t b;
		logic      is_max;
		logic      fpu0;
		n_rows = 0;
		// sign operations
		add_op(kind_fp_op, op_fneg, 32'h3f80_0000, 32'h0, 1'b0, 32'hbf80_0000);
		add_op(kind_fp_op, op_fabs, 32'hc049_0fdb, 32'h0, 1'b0, 32'h4049_0fdb);
		add_op(kind_fp_op, op_fsgnj, 32'h3f80_0000, 32'h8000_0000, 1'b0, 32'hbf80_0000);
		// signed zeros and NaN inputs of FMIN and FMAX
		add_op(kind_fp_op, op_fmin, 32'h0000_0000, 32'h8000_0000, 1'b0, 32'h8000_0000);
		add_op(kind_fp_op, op_fmax, 32'h0000_0000, 32'h8000_0000, 1'b0, 32'h0000_0000);
		add_op(kind_fp_op, op_fmin, 32'h7fc0_0001, 32'h4000_0000, 1'b0, 32'h4000_0000);
		add_op(kind_fp_op, op_fmax, 32'h3f80_0000, 32'hff80_0001, 1'b0, 32'h3f80_0000);
		add_op(kind_fp_op, op_fmin, 32'h7f80_0001, 32'hffc0_0000, 1'b0, 32'h7fc0_0000);
		add_op(kind_fp_op, op_fmax, 32'h7f80_0000, 32'h7f7f_ffff, 1'b0, 32'h7f80_0000);
		add_op(kind_fp_op, op_fmin, 32'hbf80_0000, 32'hc000_0000, 1'b0, 32'hc000_0000);
		add_op(kind_fp_op, op_fmax, 32'hbf80_0000, 32'hc000_0000, 1'b0, 32'hbf80_0000);
		add_op(kind_fp_op, op_fneg, 32'h8000_0000, 32'h0, 1'b1, 32'h0000_0000);
		add_op(kind_sync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		add_op(kind_fp_op, op_fabs, 32'hff80_0000, 32'h0, 1'b0, 32'h7f80_0000);
		add_op(kind_fp_op, op_fmin, 32'h0000_0001, 32'h0000_0002, 1'b1, 32'h0000_0001);
		add_op(kind_fsync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		add_op(kind_fp_op, op_fsgnj, 32'h4040_0000, 32'hc000_0000, 1'b0, 32'hc040_0000);
		add_op(kind_fp_op, op_fmax, 32'h8000_0000, 32'h0000_0000, 1'b1, 32'h0000_0000);
		// frozen selector, work piles up behind barriers
		add_pause(12, 1'b0, 2'b11);
		add_op(kind_fp_op, op_fneg, 32'h4120_0000, 32'h0, 1'b0, 32'hc120_0000);
		add_op(kind_sync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		add_op(kind_fp_op, op_fabs, 32'hc120_0000, 32'h0, 1'b1, 32'h4120_0000);
		add_op(kind_fsync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		add_op(kind_fp_op, op_fsgnj, 32'hc120_0000, 32'h0000_0000, 1'b0, 32'h4120_0000);
		// both FPUs disabled long enough to fill the queue
		add_pause(24, 1'b1, 2'b00);
		for (int i = 0; i < 10; i++)
			add_op(kind_fp_op, op_fneg, 32'(i) << 23, 32'h0, i[0], {1'b1, 31'(i) << 23});
		add_op(kind_fsync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		// only FPU 1 may take work
		add_pause(20, 1'b1, 2'b10);
		add_op(kind_fp_op, op_fabs, 32'hbf00_0000, 32'h0, 1'b0, 32'h3f00_0000);
		add_op(kind_fp_op, op_fneg, 32'h3f00_0000, 32'h0, 1'b1, 32'hbf00_0000);
		add_op(kind_fp_op, op_fmin, 32'h4000_0000, 32'hc000_0000, 1'b0, 32'hc000_0000);
		add_op(kind_sync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		add_op(kind_fp_op, op_fmax, 32'h4000_0000, 32'hc000_0000, 1'b0, 32'h4000_0000);
		// random FMIN and FMAX, with a barrier every eighth row
		for (int i = 0; i < 24; i++) begin
			a = random_word(32);
			b = random_word(32);
			is_max = random_word(1);
			fpu0 = random_word(2) == 0;
			add_op(kind_fp_op, is_max ? op_fmax : op_fmin, a, b, fpu0, minmax_model(is_max, a, b));
			if (i % 8 == 7)
				add_op(i % 16 == 7 ? kind_sync : kind_fsync, op_fneg, 32'h0, 32'h0, 1'b0, 32'h0);
		end
	endtask

	// =========================================================================
	// checks
	// =========================================================================

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_result(input fpu_result_t got, input fpu_word_t expected);
		if (got.value !== expected)
			fail_now($sformatf("error at %0t: tag %0d gave %08h, expected %08h",
				$time, got.tag, got.value, expected));
	endtask

	// while only FPU 1 is enabled everything must come out of result1
	task automatic check_unit(input iq_tag_t tag, input int port);
		int want;
		want = -1;
		if (pause_active && pause_en_r == 2'b10 && pause_age >= drain_cycles)
			want = 1;
		else if (exp_fpu0[tag])
			want = 0;
		if (want >= 0 && port != want)
			fail_now($sformatf("error at %0t: tag %0d arrived on result%0d, expected result%0d",
				$time, tag, port, want));
	endtask

	// a result may only arrive once every fp_op older than its barriers is done
	task automatic check_order(input iq_tag_t tag);
		for (int k = 0; k < exp_epoch[tag]; k++) begin
			if (outstanding[k] != 0)
				fail_now($sformatf("tag %0d passed a barrier with older work still pending", tag));
		end
	endtask

	task automatic retire_result(input fpu_result_t res, input int port);
		if (!pending[res.tag])
			fail_now($sformatf("tag %0d was reported with no dispatch outstanding", res.tag));
		check_result(res, exp_val[res.tag]);
		check_unit(res.tag, port);
		if (cyc - disp_cyc[res.tag] < `FPU_LATENCY + 1)
			fail_now($sformatf("tag %0d arrived too soon after its dispatch", res.tag));
		pending[res.tag] = 1'b0;
		outstanding[exp_epoch[res.tag]]--;
		open_count--;
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!arst_n) begin
			// an empty queue in reset has room and nothing in flight
			if (queue_full || result0.valid || result1.valid)
				fail_now("queue_full or a result valid was high during reset");
		end else begin
			if (queue_full)
				saw_full = 1'b1;
			if (result0.valid && result1.valid && result0.tag == result1.tag)
				fail_now("the same tag appeared on both result ports");
			if (pause_active && pause_age >= drain_cycles && (!pause_ce_r || pause_en_r == 2'b00)
					&& (result0.valid || result1.valid))
				fail_now("a result appeared while issue was stopped");
			// ordering is checked for both ports before either one retires
			if (result0.valid)
				check_order(result0.tag);
			if (result1.valid)
				check_order(result1.tag);
			if (result0.valid)
				retire_result(result0, 0);
			if (result1.valid)
				retire_result(result1, 1);
			cyc++;
			if (pause_active)
				pause_age++;
			if (cyc > cycle_limit)
				fail_now($sformatf("timeout after %0d cycles with %0d results outstanding",
					cyc, open_count));
		end
	end

	// =========================================================================
	// stimulus
	// =========================================================================

	task automatic tick_pause();
		if (pause_left > 0) begin
			pause_left--;
			if (pause_left == 0) begin
				issue_ce <= 1'b1;
				fpu_enable <= 2'b11;
				pause_active = 1'b0;
			end
		end
	endtask

	task automatic start_pause(input row_t r);
		issue_ce <= r.pause_ce;
		fpu_enable <= r.pause_en;
		pause_left = r.pause_len;
		pause_ce_r = r.pause_ce;
		pause_en_r = r.pause_en;
		pause_age = 0;
		pause_active = 1'b1;
	endtask

	task automatic send_row(input row_t r);
		iq_dispatch_t d;
		d.kind = r.kind;
		d.tag = tag_ctr;
		d.fpu0_only = r.fpu0_only;
		d.op = '{r.opcode, r.a, r.b};
		dispatch <= d;
		dispatch_valid <= 1'b1;
		if (r.kind == kind_fp_op) begin
			if (pending[tag_ctr])
				fail_now($sformatf("tag %0d reused while still outstanding", tag_ctr));
			pending[tag_ctr] = 1'b1;
			exp_val[tag_ctr] = r.expected;
			exp_fpu0[tag_ctr] = r.fpu0_only;
			exp_epoch[tag_ctr] = epoch;
			disp_cyc[tag_ctr] = cyc;
			outstanding[epoch]++;
			open_count++;
		end else begin
			epoch++;
		end
		tag_ctr++;
	endtask

	initial begin
		int   row;
		logic gap;
		clk = 1'b0;
		arst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch = '0;
		issue_ce = 1'b1;
		fpu_enable = 2'b11;
		lfsr_state = 32'h2a08_3120;
		for (int i = 0; i < 64; i++) begin
			pending[i] = 1'b0;
			outstanding[i] = 0;
		end
		open_count = 0;
		epoch = 0;
		tag_ctr = '0;
		cyc = 0;
		pause_left = 0;
		pause_active = 1'b0;
		saw_full = 1'b0;
		build_table();
		cycle_limit = n_rows * 16 + 200;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		row = 0;
		gap = 1'b0;
		// a quiet cycle after each dispatch keeps queue_full current
		while (row < n_rows) begin
			@(posedge clk);
			dispatch_valid <= 1'b0;
			tick_pause();
			if (gap) begin
				gap = 1'b0;
			end else if (rows[row].is_pause) begin
				if (pause_left == 0) begin
					start_pause(rows[row]);
					row++;
				end
			end else if (!queue_full) begin
				send_row(rows[row]);
				row++;
				gap = 1'b1;
			end
		end
		while (open_count > 0 || pause_left > 0) begin
			@(posedge clk);
			dispatch_valid <= 1'b0;
			tick_pause();
		end
		// stray results after the drain would still hit the scoreboard
		repeat (`FPU_LATENCY + 4) @(posedge clk);
		if (open_count == 0 && saw_full) begin
			$display("Regression passed");
			$finish;
		end else if (!saw_full) begin
			fail_now("queue_full never went high while the FPUs were disabled");
		end else begin
			fail_now($sformatf("%0d results never arrived", open_count));
		end
	end

endmodule
